// File: source/anim_pkg.sv
`default_nettype none

package anim_pkg;

    // Animation selection
    localparam int ANIM_WIDTH  = 3;                 // Bits of the animation index
    localparam int NUM_ANIM    = 8;                 // Animations available
    localparam int FRAME_WIDTH = 5;                 // Bits of the frame index

    // Last frame of each animation, indexed by animation
    localparam logic [FRAME_WIDTH-1:0] FRAME_LIMIT [NUM_ANIM] = '{
        5'd15,                                      // Hex counter 0 to F
        5'd5,                                       // Rotating outer segment
        5'd7,                                       // Filling ring
        5'd11,                                      // Snake
        5'd3,                                       // Blink all
        5'd9,                                       // Bouncing bar
        5'd19,                                      // Spiral
        5'd31                                       // Build and erase
    };

    // Frame rate in prescale units, larger means slower
    localparam int                    RATE_WIDTH   = 8;
    localparam logic [RATE_WIDTH-1:0] RATE_DEFAULT = 8'd100;   // After reset
    localparam logic [RATE_WIDTH-1:0] RATE_MIN     = 8'd10;    // Fastest
    localparam logic [RATE_WIDTH-1:0] RATE_MAX     = 8'd190;   // Slowest
    localparam logic [RATE_WIDTH-1:0] RATE_STEP    = 8'd10;    // Change per press

    // Active-high hex digit codes, bit 0 is segment a and bit 6 is segment g
    localparam logic [6:0] SEG_HEX [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F,                 // 0 1 2 3
        7'h66, 7'h6D, 7'h7D, 7'h07,                 // 4 5 6 7
        7'h7F, 7'h6F, 7'h77, 7'h7C,                 // 8 9 A b
        7'h39, 7'h5E, 7'h79, 7'h71                  // C d E F
    };

endpackage

`default_nettype wire

// File: source/button_debouncer.sv
`timescale 1ns/1ps
`default_nettype none

module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = 512             // High samples needed for a press
) (
    input  logic clk,
    input  logic reset,
    input  logic button,                            // Raw button level
    output logic press                              // One-cycle strobe per stable press
);

    localparam int                   CNT_WIDTH = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_WIDTH-1:0] CNT_LAST  = CNT_WIDTH'(DEBOUNCE_CYCLES - 1);

    logic [CNT_WIDTH-1:0] count;                    // Consecutive high samples so far
    logic                 armed;                    // Press may fire, cleared until release

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            armed <= 1'b1;
            press <= 1'b0;
        end else begin
            press <= 1'b0;                          // Strobe by default
            if (!button) begin
                count <= '0;                        // Any low sample restarts the count
                armed <= 1'b1;                      // Released, next press may fire
            end else if (count != CNT_LAST) begin
                count <= count + 1'b1;
            end else if (armed) begin
                press <= 1'b1;                      // Stable for DEBOUNCE_CYCLES samples
                armed <= 1'b0;                      // Hold off while still pressed
            end
        end
    end

endmodule

`default_nettype wire

// File: source/animation_selector.sv
`timescale 1ns/1ps
`default_nettype none

module animation_selector (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           next_press,      // Step forward
    input  logic                           prev_press,      // Step backward
    output logic [anim_pkg::ANIM_WIDTH-1:0] anim,           // Current animation
    output logic                           anim_changed     // High in the cycle anim moves
);

    import anim_pkg::*;

    localparam logic [ANIM_WIDTH-1:0] ANIM_LAST = ANIM_WIDTH'(NUM_ANIM - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            anim         <= '0;
            anim_changed <= 1'b0;
        end else begin
            anim_changed <= next_press | prev_press;    // Every press moves the index
            if (next_press) begin                       // Next wins over prev
                if (anim == ANIM_LAST) begin
                    anim <= '0;                         // Wrap past the last animation
                end else begin
                    anim <= anim + 1'b1;
                end
            end else if (prev_press) begin
                if (anim == '0) begin
                    anim <= ANIM_LAST;                  // Wrap below the first one
                end else begin
                    anim <= anim - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rate_controller.sv
`timescale 1ns/1ps
`default_nettype none

module rate_controller #(
    parameter int PRESCALE_CYCLES = 100000          // Clock cycles per rate unit
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            slower_press,   // Lengthen the frame period
    input  logic                            faster_press,   // Shorten the frame period
    output logic [anim_pkg::RATE_WIDTH-1:0] rate,           // Frame period in prescale units
    output logic                            frame_step      // End of each frame period
);

    import anim_pkg::*;

    localparam int                   PRE_WIDTH = $clog2(PRESCALE_CYCLES + 1);
    localparam logic [PRE_WIDTH-1:0] PRE_LAST  = PRE_WIDTH'(PRESCALE_CYCLES - 1);

    logic [PRE_WIDTH-1:0]  pre_cnt;                 // Prescaler count
    logic [RATE_WIDTH-1:0] tick_cnt;                // Ticks since last frame step
    logic                  tick;                    // Last cycle of a prescale unit

    assign tick = (pre_cnt == PRE_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            rate       <= RATE_DEFAULT;
            pre_cnt    <= '0;
            tick_cnt   <= '0;
            frame_step <= 1'b0;
        end else begin
            frame_step <= 1'b0;

            // Rate setting, slower wins, a step past a limit is refused
            if (slower_press) begin
                if (rate <= RATE_MAX - RATE_STEP) begin
                    rate <= rate + RATE_STEP;
                end
            end else if (faster_press) begin
                if (rate >= RATE_MIN + RATE_STEP) begin
                    rate <= rate - RATE_STEP;
                end
            end

            // Prescaler
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;

            // Tick counter against the live rate, also catches a rate lowered mid-count
            if (tick) begin
                if (tick_cnt >= rate - 1'b1) begin
                    tick_cnt   <= '0;
                    frame_step <= 1'b1;             // Count reached rate
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [anim_pkg::ANIM_WIDTH-1:0]  anim,          // Current animation
    input  logic                             anim_changed,  // Restart at frame 0
    input  logic                             frame_step,    // Advance one frame
    output logic [anim_pkg::FRAME_WIDTH-1:0] frame          // Current frame index
);

    import anim_pkg::*;

    logic [FRAME_WIDTH-1:0] limit;                  // Last frame of this animation

    assign limit = FRAME_LIMIT[anim];

    always_ff @(posedge clk) begin
        if (reset) begin
            frame <= '0;
        end else if (anim_changed) begin
            frame <= '0;                            // New animation starts from the top
        end else if (frame_step) begin
            if (frame >= limit) begin
                frame <= '0;                        // Wrap after the last frame
            end else begin
                frame <= frame + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/segment_pattern_rom.sv
`timescale 1ns/1ps
`default_nettype none

module segment_pattern_rom (
    input  logic [anim_pkg::ANIM_WIDTH-1:0]  anim,
    input  logic [anim_pkg::FRAME_WIDTH-1:0] frame,
    output logic [6:0]                       segments   // Active high, bit 0 is segment a
);

    import anim_pkg::*;

    logic [6:0] build;                              // Build-and-erase base pattern

    // Segments a..g as 01 02 04 08 10 20 40
    always_comb begin
        case (frame[3:0])
            4'd0:    build = 7'h00;
            4'd1:    build = 7'h01;
            4'd2:    build = 7'h03;
            4'd3:    build = 7'h07;
            4'd4:    build = 7'h0F;
            4'd5:    build = 7'h1F;
            4'd6:    build = 7'h3F;
            4'd7:    build = 7'h7F;                 // All lit
            4'd8:    build = 7'h7E;                 // Erase in the same order
            4'd9:    build = 7'h7C;
            4'd10:   build = 7'h78;
            4'd11:   build = 7'h70;
            4'd12:   build = 7'h60;
            4'd13:   build = 7'h40;
            default: build = 7'h00;                 // Short pause
        endcase
    end

    always_comb begin
        segments = 7'h00;
        case (anim)
            3'd0: segments = SEG_HEX[frame[3:0]];   // Hex counter
            3'd1: begin                             // One outer segment going round
                case (frame)
                    5'd0:    segments = 7'h01;
                    5'd1:    segments = 7'h02;
                    5'd2:    segments = 7'h04;
                    5'd3:    segments = 7'h08;
                    5'd4:    segments = 7'h10;
                    default: segments = 7'h20;
                endcase
            end
            3'd2: begin                             // Ring fills clockwise
                case (frame)
                    5'd0:    segments = 7'h00;
                    5'd1:    segments = 7'h01;
                    5'd2:    segments = 7'h03;
                    5'd3:    segments = 7'h07;
                    5'd4:    segments = 7'h0F;
                    5'd5:    segments = 7'h1F;
                    default: segments = 7'h3F;      // Full ring held
                endcase
            end
            3'd3: begin                             // Two-segment snake
                case (frame)
                    5'd0:    segments = 7'h30;      // e f
                    5'd1:    segments = 7'h21;      // f a
                    5'd2:    segments = 7'h03;      // a b
                    5'd3:    segments = 7'h42;      // b g
                    5'd4:    segments = 7'h50;      // g e
                    5'd5:    segments = 7'h18;      // e d
                    5'd6:    segments = 7'h0C;      // d c
                    5'd7:    segments = 7'h06;      // c b
                    5'd8:    segments = 7'h03;      // b a
                    5'd9:    segments = 7'h21;      // a f
                    5'd10:   segments = 7'h60;      // f g
                    default: segments = 7'h50;      // g e
                endcase
            end
            3'd4: segments = frame[0] ? 7'h00 : 7'h7F;  // Blink all
            3'd5: begin                             // Bar bounces down, then sideways
                case (frame)
                    5'd0:    segments = 7'h01;
                    5'd1:    segments = 7'h40;
                    5'd2:    segments = 7'h08;
                    5'd3:    segments = 7'h40;
                    5'd4:    segments = 7'h01;
                    5'd5:    segments = 7'h30;      // Left bar
                    5'd6:    segments = 7'h06;      // Right bar
                    5'd7:    segments = 7'h30;
                    5'd8:    segments = 7'h06;
                    default: segments = 7'h40;
                endcase
            end
            3'd6: begin                             // Counter-clockwise spiral into g
                case (frame)
                    5'd0:    segments = 7'h01;
                    5'd1:    segments = 7'h21;
                    5'd2:    segments = 7'h31;
                    5'd3:    segments = 7'h39;
                    5'd4:    segments = 7'h3D;
                    5'd5:    segments = 7'h3F;
                    5'd6:    segments = 7'h7F;
                    5'd7:    segments = 7'h7E;
                    5'd8:    segments = 7'h5E;
                    5'd9:    segments = 7'h4E;
                    5'd10:   segments = 7'h46;
                    5'd11:   segments = 7'h42;
                    5'd12:   segments = 7'h40;      // Only the centre left
                    5'd13:   segments = 7'h00;
                    5'd14:   segments = 7'h40;
                    5'd15:   segments = 7'h00;
                    5'd16:   segments = 7'h40;
                    default: segments = 7'h00;
                endcase
            end
            default: begin
                // Second half runs the same table in mirrored bit order
                segments = frame[4] ? {<<{build}} : build;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/seven_segment_animator.sv
`timescale 1ns/1ps
`default_nettype none

module seven_segment_animator #(
    parameter int PRESCALE_CYCLES = 100000,         // 10 ms units at 10 MHz
    parameter int DEBOUNCE_CYCLES = 512             // Stable samples per press
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             btn_next,      // Next animation
    input  logic                             btn_prev,      // Previous animation
    input  logic                             btn_slower,    // Slower frame rate
    input  logic                             btn_faster,    // Faster frame rate
    output logic [6:0]                       segments,
    output logic [anim_pkg::ANIM_WIDTH-1:0]  anim,
    output logic [anim_pkg::FRAME_WIDTH-1:0] frame,
    output logic [anim_pkg::RATE_WIDTH-1:0]  rate
);

    logic next_press;
    logic prev_press;
    logic slower_press;
    logic faster_press;
    logic anim_changed;                             // Restarts the frame sequence
    logic frame_step;                               // One per frame period

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_next (
        .clk(clk), .reset(reset), .button(btn_next), .press(next_press)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_prev (
        .clk(clk), .reset(reset), .button(btn_prev), .press(prev_press)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_slower (
        .clk(clk), .reset(reset), .button(btn_slower), .press(slower_press)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_deb_faster (
        .clk(clk), .reset(reset), .button(btn_faster), .press(faster_press)
    );

    animation_selector i_animation_selector (
        .clk          (clk),
        .reset        (reset),
        .next_press   (next_press),
        .prev_press   (prev_press),
        .anim         (anim),
        .anim_changed (anim_changed)
    );

    rate_controller #(.PRESCALE_CYCLES(PRESCALE_CYCLES)) i_rate_controller (
        .clk          (clk),
        .reset        (reset),
        .slower_press (slower_press),
        .faster_press (faster_press),
        .rate         (rate),
        .frame_step   (frame_step)
    );

    frame_sequencer i_frame_sequencer (
        .clk          (clk),
        .reset        (reset),
        .anim         (anim),
        .anim_changed (anim_changed),
        .frame_step   (frame_step),
        .frame        (frame)
    );

    segment_pattern_rom i_segment_pattern_rom (
        .anim     (anim),
        .frame    (frame),
        .segments (segments)
    );

endmodule

`default_nettype wire

// File: bench/tb_seven_segment_animator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_seven_segment_animator;

    localparam int PRESCALE       = 2;                      // Small prescaler for short frames
    localparam int DEBOUNCE       = 8;                      // Stable samples per press
    localparam int SEED           = 90515;
    localparam int HOLD_CYCLES    = DEBOUNCE + 4;           // Comfortably long press
    localparam int RELEASE_CYCLES = 4;                      // Low time after each press
    localparam int NUM_ANIM_REF   = 8;
    localparam int RATE_RESET     = 100;
    localparam int RATE_LO        = 10;
    localparam int RATE_HI        = 190;
    localparam int RATE_INC       = 10;
    localparam int FRAME_CYCLES   = RATE_RESET * PRESCALE;  // Frame period at reset rate
    localparam int TIMEOUT_CYCLES = 2 * 150 * FRAME_CYCLES; // Up to 150 frame periods, doubled
    localparam int BTN_NEXT       = 0;
    localparam int BTN_PREV       = 1;
    localparam int BTN_SLOWER     = 2;
    localparam int BTN_FASTER     = 3;

    // Last frame of animations 7 down to 0
    localparam logic [39:0] LIMITS = {5'd31, 5'd19, 5'd9, 5'd3, 5'd11, 5'd7, 5'd5, 5'd15};

    // Active-high hex codes, digit F down to digit 0
    localparam logic [111:0] HEX_CODES = {
        7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F, 7'h7F,
        7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F
    };

    logic       clk;
    logic       reset;
    logic       btn_next;
    logic       btn_prev;
    logic       btn_slower;
    logic       btn_faster;
    logic [6:0] segments;
    logic [2:0] anim;
    logic [4:0] frame;
    logic [7:0] rate;

    int         value_errors;                               // Wrong values seen
    int         timing_errors;                              // Late or missing events
    int         cycle_count;
    int         exp_anim;                                   // Reference animation index
    int         exp_rate;                                   // Reference rate setting
    int         anim_moves;                                 // Anim changes during last press
    int         move_cycle;                                 // First change, from the drive edge
    logic [4:0] frame_after_move;                           // Frame one cycle after anim moved
    int         rand_dummy;

    seven_segment_animator #(
        .PRESCALE_CYCLES (PRESCALE),
        .DEBOUNCE_CYCLES (DEBOUNCE)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .btn_next   (btn_next),
        .btn_prev   (btn_prev),
        .btn_slower (btn_slower),
        .btn_faster (btn_faster),
        .segments   (segments),
        .anim       (anim),
        .frame      (frame),
        .rate       (rate)
    );

    always #5 clk = ~clk;                                   // 10 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, tests did not finish", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
        value_errors++;
    endtask

    task automatic set_button(input int idx, input logic level);
        case (idx)
            BTN_NEXT:   btn_next   <= level;
            BTN_PREV:   btn_prev   <= level;
            BTN_SLOWER: btn_slower <= level;
            default:    btn_faster <= level;
        endcase
    endtask

    // Holds one button for hold samples, then low, and records how anim moved
    task automatic press_button(input int idx, input int hold);
        int         i;
        logic [2:0] last_anim;
        logic       frame_due;
        @(posedge clk);
        set_button(idx, 1'b1);
        last_anim  = anim;
        frame_due  = 1'b0;
        anim_moves = 0;
        move_cycle = -1;
        for (i = 1; i <= hold + RELEASE_CYCLES; i++) begin
            @(posedge clk);
            if (i == hold) set_button(idx, 1'b0);       // Last high sample at this edge
            if (frame_due) begin
                frame_after_move = frame;               // Cleared by anim_changed
                frame_due        = 1'b0;
            end
            if (anim !== last_anim) begin
                anim_moves++;
                if (move_cycle < 0) begin
                    move_cycle = i;
                    frame_due  = 1'b1;
                end
                last_anim = anim;
            end
        end
    endtask

    // Waits until the frame has left 0, so the clear on the next anim change is visible
    task automatic wait_frame_nonzero();
        int waited;
        waited = 0;
        while (frame === 5'd0 && waited < 2 * exp_rate * PRESCALE) begin
            @(posedge clk);
            waited++;
        end
        if (frame === 5'd0) begin
            $display("Frame stayed at 0 in animation %0d", exp_anim);
            timing_errors++;
        end
    endtask

    task automatic step_anim(input int idx);
        press_button(idx, HOLD_CYCLES);
        if (idx == BTN_NEXT) exp_anim = (exp_anim + 1) % NUM_ANIM_REF;
        else exp_anim = (exp_anim + NUM_ANIM_REF - 1) % NUM_ANIM_REF;
        if (anim !== exp_anim[2:0]) report_mismatch("anim", exp_anim, anim);
        if (anim_moves != 1) begin
            $display("Anim moved %0d times on a single press", anim_moves);
            value_errors++;
        end else if (frame_after_move !== 5'd0) begin
            report_mismatch("frame", 0, frame_after_move);
        end
    endtask

    task automatic step_rate(input int idx);
        press_button(idx, HOLD_CYCLES);
        if (idx == BTN_SLOWER && exp_rate + RATE_INC <= RATE_HI) exp_rate += RATE_INC;
        if (idx == BTN_FASTER && exp_rate - RATE_INC >= RATE_LO) exp_rate -= RATE_INC;
        if (rate !== exp_rate[7:0]) report_mismatch("rate", exp_rate, rate);
    endtask

    // Follows frame changes until the limit wraps to 0, optionally checking the hex code
    task automatic watch_frames(input logic check_hex);
        int         limit;
        int         waited;
        int         changes;
        int         exp_frame;
        logic       wrapped;
        logic       reached;
        logic       stuck;
        logic [4:0] last_frame;
        limit      = LIMITS[exp_anim*5 +: 5];
        last_frame = frame;
        wrapped    = 1'b0;
        stuck      = 1'b0;
        reached    = (frame == limit);
        changes    = 0;
        while (!wrapped && !stuck && changes < limit + 2) begin
            waited = 0;
            while (frame === last_frame && waited < 2 * exp_rate * PRESCALE) begin
                @(posedge clk);
                waited++;
            end
            if (frame === last_frame) begin
                $display("Frame stuck at %0d in animation %0d", last_frame, exp_anim);
                timing_errors++;
                stuck = 1'b1;
            end else begin
                changes++;
                exp_frame = (last_frame == limit) ? 0 : last_frame + 1;
                if (frame !== exp_frame[4:0]) report_mismatch("frame", exp_frame, frame);
                if (frame == limit) reached = 1'b1;
                if (exp_frame == 0 && frame == 5'd0) wrapped = 1'b1;
                if (check_hex && segments !== HEX_CODES[frame*7 +: 7])
                    report_mismatch("segments", HEX_CODES[frame*7 +: 7], segments);
                last_frame = frame;
            end
        end
        if (!stuck && !(reached && wrapped)) begin
            $display("Animation %0d never reached frame %0d and wrapped", exp_anim, limit);
            value_errors++;
        end
    endtask

    task automatic test_reset_state();
        @(posedge clk);
        if (anim !== 3'd0) report_mismatch("anim", 0, anim);
        if (frame !== 5'd0) report_mismatch("frame", 0, frame);
        if (rate !== RATE_RESET) report_mismatch("rate", RATE_RESET, rate);
        if (segments !== HEX_CODES[6:0]) report_mismatch("segments", HEX_CODES[6:0], segments);
    endtask

    task automatic test_debounce();
        press_button(BTN_NEXT, 3);                          // Bounce, far too short
        press_button(BTN_NEXT, DEBOUNCE - 1);               // One sample short
        if (anim !== exp_anim[2:0]) report_mismatch("anim", exp_anim, anim);
        press_button(BTN_NEXT, 300);                        // Long hold fires once
        exp_anim = (exp_anim + 1) % NUM_ANIM_REF;
        if (anim !== exp_anim[2:0]) report_mismatch("anim", exp_anim, anim);
        if (anim_moves != 1) begin
            $display("Long hold moved anim %0d times instead of once", anim_moves);
            value_errors++;
        end
        if (move_cycle < 0 || move_cycle - 1 > DEBOUNCE + 2) begin
            $display("Held button changed anim too late, %0d cycles", move_cycle - 1);
            timing_errors++;
        end
    endtask

    task automatic test_anim_wrap();
        int start;
        int i;
        start = exp_anim;
        for (i = 0; i < NUM_ANIM_REF; i++) step_anim(BTN_NEXT);
        if (anim !== start[2:0]) report_mismatch("anim", start, anim);
        step_anim(BTN_NEXT);                                // Ninth press
        while (exp_anim != 0) step_anim(BTN_PREV);
        step_anim(BTN_PREV);                                // Below 0 wraps to 7
        if (anim !== 3'd7) report_mismatch("anim", 7, anim);
    endtask

    task automatic test_frame_wrap();
        int a;
        for (a = 0; a < NUM_ANIM_REF; a++) begin
            wait_frame_nonzero();                           // Press lands on a running frame
            step_anim(BTN_NEXT);                            // From 7 the first press gives 0
            watch_frames(1'b0);
        end
    endtask

    task automatic test_hex_display();
        wait_frame_nonzero();
        step_anim(BTN_NEXT);                                // Back to the hex counter
        if (segments !== HEX_CODES[frame*7 +: 7])
            report_mismatch("segments", HEX_CODES[frame*7 +: 7], segments);
        watch_frames(1'b1);
    endtask

    task automatic test_rate_limits();
        int i;
        int n;
        for (i = 0; i < 11; i++) step_rate(BTN_SLOWER);    // Two presses past the top
        if (rate !== RATE_HI) report_mismatch("rate", RATE_HI, rate);
        for (i = 0; i < 20; i++) step_rate(BTN_FASTER);    // Two presses past the bottom
        if (rate !== RATE_LO) report_mismatch("rate", RATE_LO, rate);
        n = $urandom % 24 + 1;
        for (i = 0; i < n; i++) step_rate(BTN_SLOWER);
        n = $urandom % 24 + 1;
        for (i = 0; i < n; i++) step_rate(BTN_FASTER);
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        btn_next      = 1'b0;
        btn_prev      = 1'b0;
        btn_slower    = 1'b0;
        btn_faster    = 1'b0;
        value_errors  = 0;
        timing_errors = 0;
        cycle_count   = 0;
        exp_anim      = 0;
        exp_rate      = RATE_RESET;
        rand_dummy    = $urandom(SEED);
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        test_debounce();
        test_anim_wrap();
        test_frame_wrap();
        test_hex_display();
        test_rate_limits();                                 // Last, it leaves rate changed
        $display("Errors: %0d value, %0d timing", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
source/anim_pkg.sv
source/button_debouncer.sv
source/animation_selector.sv
source/rate_controller.sv
source/frame_sequencer.sv
source/segment_pattern_rom.sv
source/seven_segment_animator.sv
bench/tb_seven_segment_animator.sv

// File: Bender.yml
package:
  name: seven_segment_animator

sources:
  - source/anim_pkg.sv
  - source/button_debouncer.sv
  - source/animation_selector.sv
  - source/rate_controller.sv
  - source/frame_sequencer.sv
  - source/segment_pattern_rom.sv
  - source/seven_segment_animator.sv
  - target: simulation
    files:
      - bench/tb_seven_segment_animator.sv
